//--- src.f
+incdir+hw
hw/cache_pkg.sv
hw/mem_bus_pkg.sv
hw/cache_be_req_if.sv
hw/cache_ram.sv
hw/cache_read_channel.sv
hw/cache_write_channel.sv
hw/cache_backend.sv
hw/cache_control.sv
hw/cache_top.sv
test/cache_assertions.sv
test/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= src.f
BIN       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) +verilator+error+limit+1000)"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

//--- test/cache_tb.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_tb
   import mem_bus_pkg::*;
();
   localparam int NUM_ACCESSES = 51;  // reads and writes issued by the tests below

   logic clk, arst, wb_cyc, wb_stb, wb_we, wb_ack;
   mem_addr_t wb_adr, mem_addr;
   mem_strb_t wb_sel, mem_wstrb;
   mem_data_t wb_dat_w, wb_dat_r, mem_wdata, mem_rdata;
   logic mem_valid, mem_we, mem_ready, mem_rvalid;

   logic [7:0] mem_bytes [0:65535];
   logic [7:0] shadow [0:65535];  // expected contents as the master has written them
   mem_addr_t rd_log[$];
   integer seed;
   int errors = 0, passed = 0, failed = 0, valid_cycles = 0, ready_level = 3;
   logic reset_ok;

   cache_top cache_top_inst (
      .clk_i(clk), .arst_i(arst), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_sel_i(wb_sel), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r),
      .wb_ack_o(wb_ack), .mem_valid_o(mem_valid), .mem_addr_o(mem_addr), .mem_we_o(mem_we),
      .mem_wdata_o(mem_wdata), .mem_wstrb_o(mem_wstrb), .mem_ready_i(mem_ready),
      .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (NUM_ACCESSES * 40 + 40) @(posedge clk);
      $display("timeout: the tests did not finish in time");
      $display("tests failed");
      $finish;
   end

   always @(posedge clk) if (mem_valid) valid_cycles++;

   // back-end memory with one read outstanding and rvalid 1 to 3 cycles after accept
   logic rd_pending = 1'b0;
   int rd_cnt;
   mem_addr_t rd_addr;
   always @(posedge clk) begin
      logic rv_n, rdy_n;
      mem_data_t rd_n;
      if (!arst && mem_valid && mem_ready) begin
         if (mem_we) begin
            for (int b = 0; b < 4; b++)
               if (mem_wstrb[b]) mem_bytes[{mem_addr[15:2], 2'(b)}] = mem_wdata[8*b +: 8];
         end else begin
            rd_pending = 1'b1;
            rd_cnt = 1 + int'($unsigned($random(seed)) % 3);
            rd_addr = mem_addr;
            rd_log.push_back(mem_addr);
         end
      end
      rv_n = 1'b0;
      rd_n = '0;
      if (rd_pending) begin
         if (rd_cnt == 1) begin
            rv_n = 1'b1;
            rd_pending = 1'b0;
            for (int b = 0; b < 4; b++) rd_n[8*b +: 8] = mem_bytes[{rd_addr[15:2], 2'(b)}];
         end else rd_cnt--;
      end
      rdy_n = !rd_pending && (int'($unsigned($random(seed)) % 4) < ready_level);
      #1;
      mem_rvalid = rv_n;
      mem_rdata = rd_n;
      mem_ready = rdy_n;
   end

   task automatic wait_ack(output int n);
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!wb_ack);
   endtask

   // want_fills is 0 for a hit, 4 for a line fill and -1 for either
   task automatic read_check(input mem_addr_t addr, input int want_fills);
      int n, v0;
      mem_data_t exp;
      @(posedge clk);
      #1;
      rd_log.delete();
      v0 = valid_cycles;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_sel} = {3'b110, addr, 4'hf};
      wait_ack(n);
      for (int b = 0; b < 4; b++) exp[8*b +: 8] = shadow[{addr[15:2], 2'(b)}];
      assert (wb_dat_r == exp) else begin
         $display("[FAIL] %0t read %h got %h expected %h", $time, addr, wb_dat_r, exp);
         errors++;
      end
      if (want_fills == 0) begin
         assert (n - 2 == 2 && valid_cycles == v0) else begin
            $display("[FAIL] %0t hit at %h took %0d cycles, bus active", $time, addr, n - 2);
            errors++;
         end
      end
      if (want_fills == 4) begin
         assert (rd_log.size() == 4) else begin
            $display("[FAIL] %0t fill for %h made %0d reads", $time, addr, rd_log.size());
            errors++;
         end
         for (int i = 0; i < rd_log.size() && i < 4; i++)
            assert (rd_log[i] == {addr[15:4], 2'(i), 2'b00}) else begin
               $display("[FAIL] %0t fill read %0d at %h", $time, i, rd_log[i]);
               errors++;
            end
      end
      #1 {wb_cyc, wb_stb} = 2'b00;
   endtask

   task automatic write_word(input mem_addr_t addr, input mem_data_t data, input mem_strb_t sel);
      int n;
      @(posedge clk);
      #1;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_sel, wb_dat_w} = {3'b111, addr, sel, data};
      wait_ack(n);
      for (int b = 0; b < 4; b++)
         if (sel[b]) shadow[{addr[15:2], 2'(b)}] = data[8*b +: 8];
      #1 {wb_cyc, wb_stb, wb_we} = 3'b000;
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         passed++;
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: FAILED", name);
      end
   endtask

   initial begin
      int e;
      mem_addr_t a;
      seed = 32'hce39;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_sel, wb_dat_w} = '0;
      {mem_ready, mem_rvalid, mem_rdata} = '0;
      for (int i = 0; i < 65536; i++) begin
         mem_bytes[i] = 8'(i) ^ (8'(i >> 8) * 8'd7) ^ 8'h3c;
         shadow[i] = mem_bytes[i];
      end
      arst = 1'b1;
      repeat (4) @(posedge clk);
      reset_ok = !wb_ack && !mem_valid;
      #1 arst = 1'b0;

      e = errors;
      read_check(16'h0104, 4);
      read_check(16'h0a38, 4);
      report_test("cold read fill", e);
      e = errors;
      read_check(16'h0100, 0);
      read_check(16'h0a3c, 0);
      report_test("read hit", e);
      e = errors;
      write_word(16'h0108, 32'hdeadbeef, 4'b0101);  // hit
      write_word(16'h3304, 32'h12345678, 4'b1000);  // miss without allocate
      read_check(16'h0108, 0);
      read_check(16'h3304, 4);
      read_check(16'h3300, 0);
      report_test("partial write", e);
      e = errors;
      repeat (3) begin
         read_check(16'h0550, 4);
         read_check(16'h4554, 4);
      end
      report_test("set conflict", e);
      e = errors;
      ready_level = 1;
      repeat (36) begin
         a = 16'h2000 | (16'($random(seed)) & 16'h01fc);
         if ($random(seed) & 1) write_word(a, $random(seed), 4'($random(seed)) | 4'b0001);
         else read_check(a, -1);
      end
      report_test("random stalls", e);
      e = errors;
      assert (reset_ok && cache_top_inst.cache_assertions_inst.fail_cnt == 0) else begin
         $display("protocol assertions failed or bus not idle in reset");
         errors++;
      end
      report_test("protocol", e);

      $display("summary: %0d passed, %0d failing, %0d errors", passed, failed, errors);
      if (errors == 0) $display("all tests passed");
      else $display("tests failed");
      $finish;
   end

endmodule

//--- test/cache_assertions.sv
`timescale 1ns/10ps

module cache_assertions
   import mem_bus_pkg::*;
(
   input logic      clk_i,
   input logic      arst_i,
   input logic      wb_cyc_i,
   input logic      wb_stb_i,
   input logic      wb_ack_o,
   input logic      mem_valid_o,
   input mem_addr_t mem_addr_o,
   input logic      mem_we_o,
   input mem_data_t mem_wdata_o,
   input logic      mem_ready_i,
   input logic      mem_rvalid_i
);

   int   fail_cnt = 0;
   logic rd_outstanding;  // read accepted, word not yet back

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) rd_outstanding <= 1'b0;
      else if (mem_valid_o && mem_ready_i && !mem_we_o) rd_outstanding <= 1'b1;
      else if (mem_rvalid_i) rd_outstanding <= 1'b0;
   end

   a_reset_quiet: assert property (@(posedge clk_i) arst_i |-> !wb_ack_o && !mem_valid_o)
      else begin $error("ack or mem valid high in reset"); fail_cnt++; end

   a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (arst_i)
      wb_ack_o |-> wb_cyc_i && wb_stb_i)
      else begin $error("ack outside cyc and stb"); fail_cnt++; end

   a_ack_pulse: assert property (@(posedge clk_i) disable iff (arst_i) wb_ack_o |=> !wb_ack_o)
      else begin $error("ack longer than one cycle"); fail_cnt++; end

   // request held until accepted
   a_req_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_valid_o && !mem_ready_i && !rd_outstanding |=>
         mem_valid_o && $stable(mem_addr_o) && $stable(mem_we_o))
      else begin $error("mem request changed while stalled"); fail_cnt++; end

   a_wdata_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_valid_o && mem_we_o && !mem_ready_i |=> $stable(mem_wdata_o))
      else begin $error("write data changed while stalled"); fail_cnt++; end

endmodule

bind cache_top cache_assertions cache_assertions_inst (.*);

//--- hw/cache_top.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_top
   import cache_pkg::*;
   import mem_bus_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_i,
   // wishbone classic slave
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [`CACHE_ADDR_W-1:0]   wb_adr_i,
   input  logic [`CACHE_DATA_W/8-1:0] wb_sel_i,
   input  logic [`CACHE_DATA_W-1:0]   wb_dat_i,
   output logic [`CACHE_DATA_W-1:0]   wb_dat_o,
   output logic                       wb_ack_o,
   // back-end memory bus
   output logic                       mem_valid_o,
   output mem_addr_t                  mem_addr_o,
   output logic                       mem_we_o,
   output mem_data_t                  mem_wdata_o,
   output mem_strb_t                  mem_wstrb_o,
   input  logic                       mem_ready_i,
   input  logic                       mem_rvalid_i,
   input  mem_data_t                  mem_rdata_i
);

   set_t       tag_addr;
   logic       tag_we;
   tag_entry_t tag_wdata, tag_rdata;
   data_idx_t  data_addr;
   logic       data_we;
   mem_data_t  data_wdata, data_rdata;

   cache_be_req_if be_req ();

   cache_control cache_control_inst (
      .clk_i(clk_i), .arst_i(arst_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i),
      .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .tag_addr_o(tag_addr), .tag_we_o(tag_we), .tag_wdata_o(tag_wdata), .tag_rdata_i(tag_rdata),
      .data_addr_o(data_addr), .data_we_o(data_we), .data_wdata_o(data_wdata),
      .data_rdata_i(data_rdata), .req(be_req.ctrl)
   );

   cache_ram #(.entry_t(tag_entry_t), .DEPTH(`CACHE_SETS)) tag_ram_inst (
      .clk_i(clk_i), .addr_i(tag_addr), .we_i(tag_we), .wdata_i(tag_wdata), .rdata_o(tag_rdata)
   );

   cache_ram #(.entry_t(mem_data_t), .DEPTH(`CACHE_SETS * `CACHE_LINE_WORDS)) data_ram_inst (
      .clk_i(clk_i), .addr_i(data_addr), .we_i(data_we), .wdata_i(data_wdata),
      .rdata_o(data_rdata)
   );

   cache_backend cache_backend_inst (
      .clk_i(clk_i), .arst_i(arst_i), .req(be_req.be),
      .mem_valid_o(mem_valid_o), .mem_addr_o(mem_addr_o), .mem_we_o(mem_we_o),
      .mem_wdata_o(mem_wdata_o), .mem_wstrb_o(mem_wstrb_o), .mem_ready_i(mem_ready_i),
      .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
   );

endmodule

//--- hw/cache_control.sv
`timescale 1ns/10ps
`include "cache_config.svh"

module cache_control
   import cache_pkg::*;
   import mem_bus_pkg::*;
(
   input  logic          clk_i,
   input  logic          arst_i,
   input  logic          wb_cyc_i,
   input  logic          wb_stb_i,
   input  logic          wb_we_i,
   input  mem_addr_t     wb_adr_i,
   input  mem_strb_t     wb_sel_i,
   input  mem_data_t     wb_dat_i,
   output mem_data_t     wb_dat_o,
   output logic          wb_ack_o,
   output set_t          tag_addr_o,
   output logic          tag_we_o,
   output tag_entry_t    tag_wdata_o,
   input  tag_entry_t    tag_rdata_i,
   output data_idx_t     data_addr_o,
   output logic          data_we_o,
   output mem_data_t     data_wdata_o,
   input  mem_data_t     data_rdata_i,
   cache_be_req_if.ctrl  req
);

   ctrl_state_e state_q;
   cache_addr_t wb_adr, adr_q;
   logic        we_q;
   mem_strb_t   sel_q;
   mem_data_t   wdat_q, dat_q, merged;
   logic        ack_q;
   set_t        sweep_q;       // tag invalidation after reset
   logic        sweep_done_q;
   logic        start, hit, fill_done;

   assign wb_adr    = cache_addr_t'(wb_adr_i);
   // no new cycle while ack is out, the master drops stb after it
   assign start     = (state_q == ST_IDLE) & wb_cyc_i & wb_stb_i & ~ack_q & sweep_done_q;
   assign hit       = tag_rdata_i.valid & (tag_rdata_i.tag == adr_q.tag);
   assign fill_done = (state_q == ST_FILL) & ~req.busy;

   assign wb_ack_o = ack_q;
   assign wb_dat_o = dat_q;

   // read hit: lookup cycle, respond cycle, then ack
   assign req.fill_req       = (state_q == ST_LOOKUP) & ~we_q & ~hit;
   assign req.fill_line_addr = {adr_q.tag, adr_q.set};
   assign req.wr_req         = (state_q == ST_LOOKUP) & we_q;  // write-through, hit or miss
   assign req.wr_addr        = {adr_q.tag, adr_q.set, adr_q.word, {`CACHE_BYTE_OFF_W{1'b0}}};
   assign req.wr_data        = wdat_q;
   assign req.wr_strb        = sel_q;

   assign tag_we_o    = ~sweep_done_q | fill_done;
   assign tag_wdata_o = '{valid: sweep_done_q, tag: adr_q.tag};

   assign data_we_o    = ((state_q == ST_FILL) & req.fill_word_valid) |
                         ((state_q == ST_LOOKUP) & we_q & hit);
   assign data_wdata_o = (state_q == ST_FILL) ? req.fill_word_data : merged;

   always_comb begin
      for (int i = 0; i < $bits(mem_strb_t); i++) begin
         merged[8*i +: 8] = sel_q[i] ? wdat_q[8*i +: 8] : data_rdata_i[8*i +: 8];
      end
   end

   always_comb begin
      tag_addr_o  = adr_q.set;
      data_addr_o = {adr_q.set, adr_q.word};
      if (!sweep_done_q) begin
         tag_addr_o = sweep_q;
      end else if (state_q == ST_IDLE) begin
         tag_addr_o  = wb_adr.set;  // RAM read starts with the accepting edge
         data_addr_o = {wb_adr.set, wb_adr.word};
      end
      if (state_q == ST_FILL && req.fill_word_valid) begin
         data_addr_o = {adr_q.set, req.fill_word_idx};
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q      <= ST_IDLE;
         ack_q        <= 1'b0;
         sweep_q      <= '0;
         sweep_done_q <= 1'b0;
      end else begin
         ack_q <= (state_q == ST_RESPOND);
         if (!sweep_done_q) begin
            sweep_q <= sweep_q + set_t'(1);
            if (&sweep_q) sweep_done_q <= 1'b1;
         end
         case (state_q)
            ST_IDLE: begin
               if (start) state_q <= ST_LOOKUP;
            end
            ST_LOOKUP: begin
               if (we_q) state_q <= ST_WRITE;
               else if (hit) state_q <= ST_RESPOND;
               else state_q <= ST_FILL;
            end
            ST_FILL: begin
               if (!req.busy) state_q <= ST_LOOKUP;  // tag written, look again
            end
            ST_WRITE: begin
               if (!req.busy) state_q <= ST_RESPOND;
            end
            ST_RESPOND: state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         adr_q  <= wb_adr;
         we_q   <= wb_we_i;
         sel_q  <= wb_sel_i;
         wdat_q <= wb_dat_i;
      end
      if (state_q == ST_LOOKUP && hit) dat_q <= data_rdata_i;
   end

endmodule

//--- hw/cache_backend.sv
`timescale 1ns/10ps

module cache_backend
   import mem_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   cache_be_req_if.be req,
   output logic       mem_valid_o,
   output mem_addr_t  mem_addr_o,
   output logic       mem_we_o,
   output mem_data_t  mem_wdata_o,
   output mem_strb_t  mem_wstrb_o,
   input  logic       mem_ready_i,
   input  logic       mem_rvalid_i,
   input  mem_data_t  mem_rdata_i
);

   logic      wr_sel_q;  // bus owner, set by the last request taken
   logic      rd_valid, wr_valid;
   mem_addr_t rd_addr, wr_addr;
   logic      rd_busy, wr_busy;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_sel_q <= 1'b0;
      end else if (req.wr_req) begin
         wr_sel_q <= 1'b1;
      end else if (req.fill_req) begin
         wr_sel_q <= 1'b0;
      end
   end

   assign mem_valid_o = wr_sel_q ? wr_valid : rd_valid;
   assign mem_addr_o  = wr_sel_q ? wr_addr : rd_addr;
   assign mem_we_o    = wr_sel_q;
   assign req.busy    = rd_busy | wr_busy;

   cache_read_channel cache_read_channel_inst (
      .clk_i(clk_i), .arst_i(arst_i), .req(req), .busy_o(rd_busy),
      .mem_valid_o(rd_valid), .mem_addr_o(rd_addr), .mem_ready_i(mem_ready_i & ~wr_sel_q),
      .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
   );

   cache_write_channel cache_write_channel_inst (
      .clk_i(clk_i), .arst_i(arst_i), .req(req), .busy_o(wr_busy),
      .mem_valid_o(wr_valid), .mem_addr_o(wr_addr), .mem_wdata_o(mem_wdata_o),
      .mem_wstrb_o(mem_wstrb_o), .mem_ready_i(mem_ready_i & wr_sel_q)
   );

endmodule

//--- hw/cache_write_channel.sv
`timescale 1ns/10ps

module cache_write_channel
   import mem_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   cache_be_req_if.be req,
   output logic       busy_o,
   output logic       mem_valid_o,
   output mem_addr_t  mem_addr_o,
   output mem_data_t  mem_wdata_o,
   output mem_strb_t  mem_wstrb_o,
   input  logic       mem_ready_i
);

   logic valid_q;

   // busy and valid are the same here, the write ends when ready is seen
   assign mem_valid_o = valid_q;
   assign busy_o      = valid_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         valid_q <= 1'b0;
      end else if (req.wr_req) begin
         valid_q <= 1'b1;
      end else if (valid_q && mem_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req.wr_req) begin
         mem_addr_o  <= req.wr_addr;
         mem_wdata_o <= req.wr_data;
         mem_wstrb_o <= req.wr_strb;
      end
   end

endmodule

//--- hw/cache_read_channel.sv
`timescale 1ns/10ps
`include "cache_config.svh"

// line fill: one read outstanding at a time, the memory keeps ready low
// until it has returned rvalid for the accepted word
module cache_read_channel
   import mem_bus_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   cache_be_req_if.be req,
   output logic       busy_o,
   output logic       mem_valid_o,
   output mem_addr_t  mem_addr_o,
   input  logic       mem_ready_i,
   input  logic       mem_rvalid_i,
   input  mem_data_t  mem_rdata_i
);

   typedef enum logic [1:0] {RD_IDLE, RD_BURST, RD_END} rd_state_e;

   rd_state_e state_q;
   word_idx_t idx_q;       // words received so far
   word_idx_t word_cnt;    // word currently requested
   logic      pending_q;
   logic      got_word;
   logic      last_word;

   assign got_word  = (state_q == RD_BURST) & mem_rvalid_i & pending_q;
   assign last_word = &idx_q;

   assign mem_addr_o = {req.fill_line_addr, word_cnt, {`CACHE_BYTE_OFF_W{1'b0}}};

   assign req.fill_word_valid = got_word;
   assign req.fill_word_idx   = idx_q;
   assign req.fill_word_data  = mem_rdata_i;

   assign busy_o = (state_q != RD_IDLE);

   always_comb begin
      mem_valid_o = 1'b0;
      word_cnt    = '0;
      if (state_q == RD_BURST) begin
         mem_valid_o = ~(got_word & last_word);  // drop only with the last word
         word_cnt    = idx_q + word_idx_t'(got_word);
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= RD_IDLE;
         idx_q     <= '0;
         pending_q <= 1'b0;
      end else begin
         idx_q <= word_cnt;
         if (mem_valid_o && mem_ready_i) begin
            pending_q <= 1'b1;
         end else if (mem_rvalid_i) begin
            pending_q <= 1'b0;
         end
         case (state_q)
            RD_IDLE: begin
               if (req.fill_req) state_q <= RD_BURST;
            end
            RD_BURST: begin
               if (got_word && last_word) state_q <= RD_END;
            end
            RD_END: state_q <= RD_IDLE;  // end of handshake, busy still high
            default: state_q <= RD_IDLE;
         endcase
      end
   end

endmodule

//--- hw/cache_ram.sv
`timescale 1ns/10ps

module cache_ram #(
   parameter type entry_t = logic [31:0],
   parameter int  DEPTH   = 16
) (
   input  logic                     clk_i,
   input  logic [$clog2(DEPTH)-1:0] addr_i,
   input  logic                     we_i,
   input  entry_t                   wdata_i,
   output entry_t                   rdata_o
);

   entry_t mem_q [DEPTH];

   // registered read, a write shows its new value on the next cycle
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem_q[addr_i] <= wdata_i;
         rdata_o       <= wdata_i;
      end else begin
         rdata_o <= mem_q[addr_i];
      end
   end

endmodule

//--- hw/cache_be_req_if.sv
`timescale 1ns/10ps

interface cache_be_req_if
   import mem_bus_pkg::*;
();
   logic       fill_req;         // one cycle pulse
   line_addr_t fill_line_addr;
   logic       wr_req;           // one cycle pulse
   mem_addr_t  wr_addr;
   mem_data_t  wr_data;
   mem_strb_t  wr_strb;

   logic       fill_word_valid;
   word_idx_t  fill_word_idx;
   mem_data_t  fill_word_data;
   logic       busy;             // request fields must hold while high

   modport ctrl (
      output fill_req, fill_line_addr, wr_req, wr_addr, wr_data, wr_strb,
      input  fill_word_valid, fill_word_idx, fill_word_data, busy
   );

   modport be (
      input  fill_req, fill_line_addr, wr_req, wr_addr, wr_data, wr_strb,
      output fill_word_valid, fill_word_idx, fill_word_data, busy
   );

endinterface

//--- hw/mem_bus_pkg.sv
`include "cache_config.svh"

package mem_bus_pkg;

   localparam int LINE_ADDR_W = `CACHE_ADDR_W - `CACHE_WORD_OFF_W - `CACHE_BYTE_OFF_W;

   typedef logic [`CACHE_ADDR_W-1:0] mem_addr_t;
   typedef logic [`CACHE_DATA_W-1:0] mem_data_t;
   typedef logic [`CACHE_DATA_W/8-1:0] mem_strb_t;
   typedef logic [`CACHE_WORD_OFF_W-1:0] word_idx_t;

   // byte address without word and byte offset
   typedef logic [LINE_ADDR_W-1:0] line_addr_t;

endpackage

//--- hw/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

   localparam int TAG_W = `CACHE_ADDR_W - `CACHE_SET_W - `CACHE_WORD_OFF_W - `CACHE_BYTE_OFF_W;

   typedef logic [TAG_W-1:0] tag_t;
   typedef logic [`CACHE_SET_W-1:0] set_t;
   typedef logic [`CACHE_SET_W+`CACHE_WORD_OFF_W-1:0] data_idx_t;  // set and word

   // wishbone byte address split into its cache fields
   typedef struct packed {
      tag_t                          tag;
      set_t                          set;
      logic [`CACHE_WORD_OFF_W-1:0]  word;
      logic [`CACHE_BYTE_OFF_W-1:0]  byte_off;
   } cache_addr_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   typedef enum logic [2:0] {ST_IDLE, ST_LOOKUP, ST_FILL, ST_WRITE, ST_RESPOND} ctrl_state_e;

endpackage

//--- hw/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// wishbone byte address width
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32

// line and set geometry, as log2
`define CACHE_WORD_OFF_W 2
`define CACHE_SET_W 4

`define CACHE_BYTE_OFF_W ($clog2(`CACHE_DATA_W / 8))
`define CACHE_LINE_WORDS (1 << `CACHE_WORD_OFF_W)
`define CACHE_SETS (1 << `CACHE_SET_W)

`endif
